// ==== hdl/memStage_cfg.svh ====
`ifndef MEMSTAGE_CFG_SVH
`define MEMSTAGE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// data RAM geometry
//////////////////////////////////////////////////////////////////////

// word address width, 8 bits gives 256 words (1 KiB)
`define RAM_ADDR_BITS 8

//////////////////////////////////////////////////////////////////////
// data RAM timing
//////////////////////////////////////////////////////////////////////

// cycles between first sampled req and rising ack
`define RAM_WAIT 2

`endif

// ==== hdl/memPkg.sv ====
`default_nettype none

`include "memStage_cfg.svh"

package memPkg;

    typedef logic [31:0] word_t;                     // data or byte address
    typedef logic [4:0] regId_t;
    typedef logic [3:0] laneMask_t;                  // one bit per byte lane
    typedef logic [`RAM_ADDR_BITS-1:0] ramAddr_t;    // word index into RAM

    // execute-stage operation seen by the memory stage
    typedef enum logic [3:0] {
        NONE,       // alu pass-through
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWL,
        LWR,
        SB,
        SH,
        SW,
        SWL,
        SWR
    } memOp_t;

    // four-phase master
    typedef enum logic [1:0] {
        IDLE,
        REQ,        // req high, waiting for ack
        RELEASE     // req dropped, waiting for ack to fall
    } busState_t;

endpackage

`default_nettype wire

// ==== hdl/dataBusIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// one four-phase req/ack data bus transaction
interface dataBusIf;

    logic                 req;
    logic                 we;
    memPkg::word_t        addr;     // byte address, low bits zero
    memPkg::laneMask_t    be;
    memPkg::word_t        wdata;
    logic                 ack;
    memPkg::word_t        rdata;    // valid while ack high

    modport master (
        output req,
        output we,
        output addr,
        output be,
        output wdata,
        input  ack,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  be,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// ==== hdl/loadAligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module loadAligner (
    input  wire memPkg::memOp_t   op,
    input  wire [1:0]             offset,
    input  wire memPkg::word_t    rdata,
    input  wire                   regWe,
    output memPkg::word_t         result,
    output memPkg::laneMask_t     regMask
);

    memPkg::word_t     shiftedDown;
    memPkg::word_t     shiftedUp;
    memPkg::laneMask_t fullMask;

    assign shiftedDown = rdata >> {offset, 3'b000};   // addressed byte to lane 0
    assign shiftedUp   = rdata << {offset, 3'b000};   // lwl
    assign fullMask    = {4{regWe}};

    //////////////////////////////////////////////////////////////////////
    // data extraction and extension
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            memPkg::LB: begin
                result = {{24{shiftedDown[7]}}, shiftedDown[7:0]};
            end
            memPkg::LBU: begin
                result = {24'h000000, shiftedDown[7:0]};
            end
            memPkg::LH: begin
                result = {{16{shiftedDown[15]}}, shiftedDown[15:0]};
            end
            memPkg::LHU: begin
                result = {16'h0000, shiftedDown[15:0]};
            end
            memPkg::LWL: begin
                result = shiftedUp;
            end
            default: begin
                result = shiftedDown;    // lw, lwr
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // register byte-write mask
    //////////////////////////////////////////////////////////////////////

    // writeback merges unaligned loads lane by lane
    always_comb begin
        case (op)
            memPkg::LWR: begin
                regMask = fullMask >> offset;
            end
            memPkg::LWL: begin
                regMask = fullMask << (~offset);
            end
            default: begin
                regMask = fullMask;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/memStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memStage (
    input  wire                   Clk,
    input  wire                   arstN,
    input  wire                   flush,
    input  wire memPkg::memOp_t   eOp,
    input  wire memPkg::word_t    eAddrData,
    input  wire memPkg::word_t    eStoreData,
    input  wire memPkg::regId_t   eRtId,
    input  wire                   eRegWe,
    input  wire memPkg::regId_t   eRegId,
    input  wire memPkg::word_t    ePc,
    output logic                  stall,
    output logic                  mRegWe,
    output memPkg::laneMask_t     mRegMask,
    output memPkg::regId_t        mRegId,
    output memPkg::word_t         mData,
    output memPkg::word_t         mPc,
    dataBusIf.master              bus
);

    logic [1:0]        offset;
    logic              isLoad;
    logic              isStore;
    logic              isMem;
    memPkg::word_t     storeSrc;
    memPkg::word_t     laneData;
    memPkg::laneMask_t laneBe;
    memPkg::word_t     loadResult;
    memPkg::laneMask_t loadMask;
    memPkg::busState_t state;
    logic              abandon;     // flushed while in flight
    logic              startReq;
    logic              done;

    assign offset = eAddrData[1:0];

    always_comb begin
        case (eOp)
            memPkg::LB, memPkg::LBU, memPkg::LH, memPkg::LHU,
            memPkg::LW, memPkg::LWL, memPkg::LWR: begin
                isLoad  = 1'b1;
                isStore = 1'b0;
            end
            memPkg::SB, memPkg::SH, memPkg::SW, memPkg::SWL, memPkg::SWR: begin
                isLoad  = 1'b0;
                isStore = 1'b1;
            end
            default: begin
                isLoad  = 1'b0;
                isStore = 1'b0;
            end
        endcase
    end

    assign isMem = isLoad | isStore;

    //////////////////////////////////////////////////////////////////////
    // store data path
    //////////////////////////////////////////////////////////////////////

    // rt written by the instruction now in M
    assign storeSrc = (eRtId != '0 && mRegWe && mRegId == eRtId) ? mData : eStoreData;

    assign laneData = (eOp == memPkg::SWL) ? storeSrc >> {~offset, 3'b000}
                                           : storeSrc << {offset, 3'b000};

    always_comb begin
        case (eOp)
            memPkg::SB:  laneBe = 4'b0001 << offset;
            memPkg::SH:  laneBe = 4'b0011 << offset;
            memPkg::SWL: laneBe = 4'b1111 >> (~offset);
            memPkg::SWR: laneBe = 4'b1111 << offset;
            default:     laneBe = 4'b1111;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // bus master
    //////////////////////////////////////////////////////////////////////

    assign startReq = (state == memPkg::IDLE) && isMem && !flush;
    assign done     = (state == memPkg::REQ) && bus.ack && !abandon;
    assign stall    = isMem && !done;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state   <= memPkg::IDLE;
            bus.req <= 1'b0;
            abandon <= 1'b0;
        end else begin
            case (state)
                memPkg::IDLE: begin
                    if (startReq) begin
                        state   <= memPkg::REQ;
                        bus.req <= 1'b1;
                    end
                end
                memPkg::REQ: begin
                    if (bus.ack) begin
                        state   <= memPkg::RELEASE;
                        bus.req <= 1'b0;
                        abandon <= 1'b0;
                    end else if (flush) begin
                        abandon <= 1'b1;    // let it finish, drop the result
                    end
                end
                memPkg::RELEASE: begin
                    if (!bus.ack) state <= memPkg::IDLE;
                end
                default: begin
                    state <= memPkg::IDLE;
                end
            endcase
        end
    end

    // held for the whole transaction
    always_ff @(posedge Clk) begin
        if (startReq) begin
            bus.we    <= isStore;
            bus.addr  <= {eAddrData[31:2], 2'b00};
            bus.be    <= laneBe;
            bus.wdata <= laneData;
        end
    end

    loadAligner u_loadAligner (
        .op      (eOp),
        .offset  (offset),
        .rdata   (bus.rdata),
        .regWe   (eRegWe),
        .result  (loadResult),
        .regMask (loadMask)
    );

    //////////////////////////////////////////////////////////////////////
    // M register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            mRegWe   <= 1'b0;
            mRegMask <= '0;
        end else if (flush) begin
            mRegWe   <= 1'b0;
            mRegMask <= '0;
        end else if (!stall) begin
            mRegWe   <= eRegWe && !isStore;
            mRegMask <= isStore ? 4'b0000 : loadMask;
        end
    end

    always_ff @(posedge Clk) begin
        if (!flush && !stall) begin
            mRegId <= eRegId;
            mData  <= isLoad ? loadResult : eAddrData;
            mPc    <= ePc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dataRam.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "memStage_cfg.svh"

module dataRam (
    input  wire        Clk,
    input  wire        arstN,
    dataBusIf.slave    bus
);

    localparam int unsigned Depth = 1 << `RAM_ADDR_BITS;

    memPkg::word_t    mem [Depth];
    memPkg::ramAddr_t wordAddr;
    logic [7:0]       waitCnt;
    logic             commit;      // ack about to rise

    assign wordAddr = bus.addr[`RAM_ADDR_BITS+1:2];
    assign commit   = bus.req && !bus.ack && (waitCnt == 8'(`RAM_WAIT));

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            bus.ack <= 1'b0;
            waitCnt <= '0;
        end else if (bus.ack) begin
            if (!bus.req) bus.ack <= 1'b0;    // phase 4
        end else if (commit) begin
            bus.ack <= 1'b1;
            waitCnt <= '0;
        end else if (bus.req) begin
            waitCnt <= waitCnt + 8'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // read data holds until the next access
    always_ff @(posedge Clk) begin
        if (commit) begin
            bus.rdata <= mem[wordAddr];
            for (int i = 0; i < 4; i++) begin
                if (bus.we && bus.be[i]) begin
                    mem[wordAddr][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memSubsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module memSubsystem (
    input  wire                   Clk,
    input  wire                   arstN,
    input  wire                   flush,
    input  wire memPkg::memOp_t   eOp,
    input  wire memPkg::word_t    eAddrData,    // alu result or effective address
    input  wire memPkg::word_t    eStoreData,
    input  wire memPkg::regId_t   eRtId,
    input  wire                   eRegWe,
    input  wire memPkg::regId_t   eRegId,
    input  wire memPkg::word_t    ePc,
    output wire                   stall,
    output wire                   mRegWe,
    output memPkg::laneMask_t     mRegMask,
    output memPkg::regId_t        mRegId,
    output memPkg::word_t         mData,
    output memPkg::word_t         mPc
);

    //////////////////////////////////////////////////////////////////////
    // data bus between the stage and the RAM
    //////////////////////////////////////////////////////////////////////

    dataBusIf busIf ();

    memStage u_memStage (
        .Clk        (Clk),
        .arstN      (arstN),
        .flush      (flush),
        .eOp        (eOp),
        .eAddrData  (eAddrData),
        .eStoreData (eStoreData),
        .eRtId      (eRtId),
        .eRegWe     (eRegWe),
        .eRegId     (eRegId),
        .ePc        (ePc),
        .stall      (stall),
        .mRegWe     (mRegWe),
        .mRegMask   (mRegMask),
        .mRegId     (mRegId),
        .mData      (mData),
        .mPc        (mPc),
        .bus        (busIf.master)
    );

    dataRam u_dataRam (
        .Clk   (Clk),
        .arstN (arstN),
        .bus   (busIf.slave)
    );

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic Clk,
    output logic arstN
);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;    // 4 ns period
    end

    // released just after the fifth rising edge
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge Clk);
        #1;
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/memSubsystem_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "memStage_cfg.svh"

module memSubsystem_checker (
    input wire                    Clk,
    input wire                    arstN,
    input wire                    req,
    input wire                    ack,
    input wire                    we,
    input wire memPkg::word_t     addr,
    input wire memPkg::laneMask_t be,
    input wire memPkg::word_t     wdata
);

    //////////////////////////////////////////////////////////////////////
    // four-phase handshake
    //////////////////////////////////////////////////////////////////////

    reqHeld: assert property (@(posedge Clk) disable iff (!arstN) req && !ack |=> req)
        else $error("req dropped before ack was seen");

    noReqUnderAck: assert property (@(posedge Clk) disable iff (!arstN) $rose(req) |-> !ack)
        else $error("req rose while ack was still high");

    masterStable: assert property (@(posedge Clk) disable iff (!arstN)
        req && $past(req) |-> $stable({we, addr, be, wdata}))
        else $error("master signals changed while req was high");

    // wait counter, then one more edge for the ack register
    ackLatency: assert property (@(posedge Clk) disable iff (!arstN)
        $rose(req) |-> ##(`RAM_WAIT + 1) ack)
        else $error("ack did not follow req after the RAM wait cycles");

endmodule

bind memStage memSubsystem_checker u_checker (
    .Clk   (Clk),
    .arstN (arstN),
    .req   (bus.req),
    .ack   (bus.ack),
    .we    (bus.we),
    .addr  (bus.addr),
    .be    (bus.be),
    .wdata (bus.wdata)
);

`default_nettype wire

// ==== test/memSubsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "memStage_cfg.svh"

module memSubsystem_tb;

    // worst op count times cycles per op, margin for reset and the flush retry
    localparam int TimeoutCycles = 300 * (`RAM_WAIT + 4) + 500;

    logic              Clk, arstN, flush, eRegWe, stall, mRegWe;
    memPkg::memOp_t    eOp;
    memPkg::word_t     eAddrData, eStoreData, ePc, mData, mPc;
    memPkg::regId_t    eRtId, eRegId, mRegId;
    memPkg::laneMask_t mRegMask;

    // reference RAM, one entry per byte
    logic [7:0]        refMem [4 << `RAM_ADDR_BITS];
    logic [31:0]       rngState;
    logic [31:0]       pcCount;
    int                cycleCount = 0;
    memPkg::memOp_t    curOp;
    logic              expWe, lastWe, isStoreOp;
    memPkg::word_t     expData, expPc, lastData;
    memPkg::regId_t    expId, lastId;
    memPkg::laneMask_t expMask;

    clockGen u_clockGen (.Clk(Clk), .arstN(arstN));

    memSubsystem u_memSubsystem (.*);

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            $display("timeout: operations did not finish within %0d cycles", TimeoutCycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rnd();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // every byte follows the byte address
    function automatic memPkg::word_t fillWord(input int a);
        logic [7:0] b;
        b = 8'(a);
        return {b ^ 8'hA5, ~b, b + 8'h3C, b * 8'd7};
    endfunction

    function automatic logic [7:0] pick(input memPkg::word_t w, input int idx);
        if (idx < 0 || idx > 3) return 8'h00;    // shifted out
        return w[8*idx +: 8];
    endfunction

    function automatic logic laneOn(input memPkg::memOp_t op, input int off, input int j);
        case (op)
            memPkg::SB:  return j == off;
            memPkg::SH:  return j == off || j == off + 1;
            memPkg::SWL: return j <= off;
            memPkg::SWR: return j >= off;
            default:     return 1'b1;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // operation driver
    //////////////////////////////////////////////////////////////////////

    task automatic presentOp(input memPkg::memOp_t op, input memPkg::word_t addr,
                             input memPkg::word_t sdata, input memPkg::regId_t rt,
                             input logic we, input memPkg::regId_t rd);
        int            off;
        int            base;
        memPkg::word_t src;
        memPkg::word_t w;
        memPkg::word_t down;
        memPkg::word_t up;
        off  = int'(addr[1:0]);
        base = int'({addr[`RAM_ADDR_BITS+1:2], 2'b00});
        src  = (rt != 5'd0 && lastWe && lastId == rt) ? lastData : sdata;    // rt forwarding
        for (int j = 0; j < 4; j++) w[8*j +: 8] = refMem[base + j];
        for (int j = 0; j < 4; j++) begin
            down[8*j +: 8] = pick(w, j + off);    // addressed byte to lane 0
            up[8*j +: 8]   = pick(w, j - off);
        end
        curOp     = op;
        isStoreOp = op inside {memPkg::SB, memPkg::SH, memPkg::SW, memPkg::SWL, memPkg::SWR};
        expWe     = we && !isStoreOp;
        case (op)
            memPkg::LB:  expData = {{24{down[7]}}, down[7:0]};
            memPkg::LBU: expData = {24'd0, down[7:0]};
            memPkg::LH:  expData = {{16{down[15]}}, down[15:0]};
            memPkg::LHU: expData = {16'd0, down[15:0]};
            memPkg::LWL: expData = up;
            memPkg::LW, memPkg::LWR: expData = down;
            default:     expData = addr;
        endcase
        for (int j = 0; j < 4; j++) begin
            expMask[j] = expWe && (op == memPkg::LWR ? j <= 3 - off :
                                   op == memPkg::LWL ? j >= 3 - off : 1'b1);
            if (isStoreOp && laneOn(op, off, j)) begin
                refMem[base + j] = (op == memPkg::SWL) ? pick(src, j + 3 - off)
                                                       : pick(src, j - off);
            end
        end
        expId      = rd;
        expPc      = pcCount;
        eOp        = op;
        eAddrData  = addr;
        eStoreData = sdata;
        eRtId      = rt;
        eRegWe     = we;
        eRegId     = rd;
        ePc        = pcCount;
        pcCount   += 4;
    endtask

    // waits for stall low before an edge, then checks the M register
    task automatic completeOp();
        int waits;
        waits = 0;
        @(negedge Clk);
        while (stall) begin
            waits++;
            @(negedge Clk);
        end
        @(posedge Clk);
        #1;
        if (curOp == memPkg::NONE) checkValue("NONE op stall cycles", waits, 0);
        checkValue("mRegWe", 32'(mRegWe), 32'(expWe));
        checkValue("mRegMask", 32'(mRegMask), 32'(expMask));
        checkValue("mRegId", 32'(mRegId), 32'(expId));
        checkValue("mPc", mPc, expPc);
        if (!isStoreOp) checkValue("mData", mData, expData);
        lastWe   = expWe;
        lastId   = expId;
        lastData = expData;
    endtask

    task automatic issue(input memPkg::memOp_t op, input memPkg::word_t addr,
                         input memPkg::word_t sdata, input memPkg::regId_t rt,
                         input logic we, input memPkg::regId_t rd);
        presentOp(op, addr, sdata, rt, we, rd);
        completeOp();
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        memPkg::memOp_t op;
        memPkg::word_t  addr;
        logic [31:0]    r;
        flush      = 1'b0;
        eOp        = memPkg::NONE;
        eAddrData  = '0;
        eStoreData = '0;
        eRtId      = '0;
        eRegWe     = 1'b0;
        eRegId     = '0;
        ePc        = '0;
        rngState   = 32'd31699;
        pcCount    = 32'h0040_0000;
        lastWe     = 1'b0;
        lastId     = '0;
        lastData   = '0;

        wait (arstN === 1'b1);
        checkValue("mRegWe after reset", 32'(mRegWe), 0);
        checkValue("mRegMask after reset", 32'(mRegMask), 0);
        checkValue("req after reset", 32'(u_memSubsystem.busIf.req), 0);
        checkValue("stall after reset", 32'(stall), 0);
        @(posedge Clk);
        #1;

        issue(memPkg::NONE, 32'hDEADBEEF, 32'd0, 5'd0, 1'b1, 5'd7);
        for (int a = 0; a < 64; a += 4) issue(memPkg::SW, a, fillWord(a), 5'd0, 1'b0, 5'd0);

        // partial stores merge into the filled words
        issue(memPkg::SB, 32'h01, 32'h000000C3, 5'd0, 1'b0, 5'd0);
        issue(memPkg::SH, 32'h06, 32'h0000B00B, 5'd0, 1'b0, 5'd0);
        issue(memPkg::LW, 32'h00, 32'd0, 5'd0, 1'b1, 5'd1);
        issue(memPkg::LW, 32'h04, 32'd0, 5'd0, 1'b1, 5'd2);

        issue(memPkg::SW, 32'h10, 32'h80FF7F01, 5'd0, 1'b0, 5'd0);
        for (int off = 0; off < 4; off++) begin
            issue(memPkg::LB, 32'h10 + off, 32'd0, 5'd0, 1'b1, 5'd3);
            issue(memPkg::LBU, 32'h10 + off, 32'd0, 5'd0, 1'b1, 5'd4);
            issue(memPkg::LH, 32'h10 + off, 32'd0, 5'd0, 1'b1, 5'd5);
            issue(memPkg::LHU, 32'h10 + off, 32'd0, 5'd0, 1'b1, 5'd6);
        end

        // unaligned word access
        for (int off = 0; off < 4; off++) begin
            issue(memPkg::LWL, 32'h20 + off, 32'd0, 5'd0, 1'b1, 5'd3);
            issue(memPkg::LWR, 32'h20 + off, 32'd0, 5'd0, 1'b1, 5'd4);
            issue(memPkg::SWL, 32'h24 + off, 32'h11223344, 5'd0, 1'b0, 5'd0);
            issue(memPkg::LW, 32'h24, 32'd0, 5'd0, 1'b1, 5'd5);
            issue(memPkg::SWR, 32'h28 + off, 32'h55667788, 5'd0, 1'b0, 5'd0);
            issue(memPkg::LW, 32'h28, 32'd0, 5'd0, 1'b1, 5'd6);
        end

        // store data taken from M
        issue(memPkg::NONE, 32'hCAFEF00D, 32'd0, 5'd0, 1'b1, 5'd9);
        issue(memPkg::SW, 32'h30, 32'h0BADF00D, 5'd9, 1'b0, 5'd0);
        issue(memPkg::LW, 32'h30, 32'd0, 5'd0, 1'b1, 5'd10);
        issue(memPkg::SB, 32'h37, 32'h00000011, 5'd10, 1'b0, 5'd0);
        issue(memPkg::LW, 32'h34, 32'd0, 5'd0, 1'b1, 5'd11);

        // flush in the middle of a stalled load
        issue(memPkg::NONE, 32'h12345678, 32'd0, 5'd0, 1'b1, 5'd5);
        presentOp(memPkg::LW, 32'h32, 32'd0, 5'd0, 1'b1, 5'd6);
        do begin
            @(posedge Clk);
            #1;
        end while (!u_memSubsystem.busIf.req);    // request already on the bus
        flush = 1'b1;
        @(posedge Clk);
        #1;
        flush = 1'b0;
        checkValue("mRegWe after flush", 32'(mRegWe), 0);
        checkValue("mRegMask after flush", 32'(mRegMask), 0);
        lastWe = 1'b0;
        completeOp();

        for (int i = 0; i < 200; i++) begin
            r    = rnd();
            op   = memPkg::memOp_t'(4'(r[7:0] % 8'd13));
            addr = (op == memPkg::NONE) ? rnd() : {26'd0, r[13:8]};
            issue(op, addr, rnd(), {3'd0, r[17:16]}, r[20], {3'd0, r[25:24]});
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/memPkg.sv
hdl/dataBusIf.sv
hdl/loadAligner.sv
hdl/memStage.sv
hdl/dataRam.sv
hdl/memSubsystem.sv
test/clockGen.sv
test/memSubsystem_checker.sv
test/memSubsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module memSubsystem_tb \
    -o memSubsystem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/memSubsystem_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
